/* source/isa_pkg.sv */
// ##########################################################################
// instruction-set types for the mips_lite core
// encodings of the supported subset, imported by every block that decodes
// ##########################################################################
package isa_pkg;

    // architectural widths
    typedef logic [63:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  regnum_t;
    typedef logic [63:0] addr_t;

    // major opcodes, R-type is all zeros
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // function field of the R-type ops we keep
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    // alu operations, add is zero so a bubble decodes as add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // instruction rom depth in words
    localparam int ROM_WORDS = 64;
    localparam int ROM_AW    = $clog2(ROM_WORDS);

endpackage

/* source/pipe_pkg.sv */
// ##########################################################################
// pipeline register layouts and data memory timing for the mips_lite core
// all-zero contents of any stage register is a bubble
// ##########################################################################
package pipe_pkg;
    import isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } if_regs_t;

    // decode to execute, operands already forwarded
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    write_enable;
        word_t   a;
        word_t   b;
        word_t   imm;
        regnum_t dest;
    } id_regs_t;

    // execute to memory, also drives the data request
    typedef struct packed {
        word_t   result;
        word_t   store_data;
        logic    mem_read;
        logic    mem_write;
        logic    write_enable;
        regnum_t dest;
    } ex_regs_t;

    // memory to writeback
    typedef struct packed {
        logic    write_enable;
        regnum_t dest;
        word_t   data;
    } mem_regs_t;

    // where a decode operand is taken from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // data ram size and wait states before ready
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);
    localparam int RAM_WAIT  = 2;
    localparam int WAIT_W    = $clog2(RAM_WAIT + 2);

endpackage

/* source/core_hazard.sv */
// ##########################################################################
// hazard unit for the decode stage
// picks operand forwarding sources and raises the stall and wait controls
// ##########################################################################
`timescale 1ns/1ps

module core_hazard
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  regnum_t   rs,
    input  regnum_t   rt,
    input  id_regs_t  id_ex,
    input  ex_regs_t  ex_mem,
    input  mem_regs_t mem_wb,
    input  logic      d_valid,
    input  logic      d_ready,
    output logic      stall,
    output logic      mem_wait,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b
);

    // write_enable is never set for r0, so r0 always reads the file
    always_comb begin
        fwd_a = FWD_REG;
        if (ex_mem.write_enable && ex_mem.dest == rs) begin
            fwd_a = FWD_MEM;
        end else if (mem_wb.write_enable && mem_wb.dest == rs) begin
            fwd_a = FWD_WB;
        end
    end

    // same priority for the second operand, newest first
    always_comb begin
        fwd_b = FWD_REG;
        if (ex_mem.write_enable && ex_mem.dest == rt) begin
            fwd_b = FWD_MEM;
        end else if (mem_wb.write_enable && mem_wb.dest == rt) begin
            fwd_b = FWD_WB;
        end
    end

    // load-use case, also any other producer still in ex
    // its result only exists once ex_mem is clocked
    assign stall = id_ex.write_enable && (id_ex.dest == rs || id_ex.dest == rt);

    // request out, no answer yet
    assign mem_wait = d_valid && !d_ready;

endmodule

/* source/core_fetch_decode.sv */
// ##########################################################################
// fetch and decode stages of the core
// pc, if/id, register file, forwarding muxes, branch check and id/ex
// ##########################################################################
`timescale 1ns/1ps

module core_fetch_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  inst_t     i_data,
    input  logic      stall,
    input  logic      mem_wait,
    input  fwd_sel_t  fwd_a,
    input  fwd_sel_t  fwd_b,
    input  ex_regs_t  ex_mem,
    input  mem_regs_t mem_wb,
    output addr_t     i_addr,
    output if_regs_t  if_id,
    output regnum_t   rs,
    output regnum_t   rt,
    output id_regs_t  id_ex
);

    addr_t    pc;
    word_t    regs [32];
    opcode_t  opcode;
    funct_t   funct;
    regnum_t  rd;
    word_t    imm;
    word_t    op_a;
    word_t    op_b;
    id_regs_t dec;
    logic     is_beq;
    logic     is_bne;
    logic     taken;
    addr_t    target;

    // instruction fields
    assign opcode = opcode_t'(if_id.inst[31:26]);
    assign funct  = funct_t'(if_id.inst[5:0]);
    assign rs     = if_id.inst[25:21];
    assign rt     = if_id.inst[20:16];
    assign rd     = if_id.inst[15:11];
    assign imm    = {{48{if_id.inst[15]}}, if_id.inst[15:0]};
    assign i_addr = pc;

    // operand muxes, ex_mem already carries load data when ready
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = ex_mem.result;
            FWD_WB:  op_a = mem_wb.data;
            default: op_a = regs[rs];
        endcase
        case (fwd_b)
            FWD_MEM: op_b = ex_mem.result;
            FWD_WB:  op_b = mem_wb.data;
            default: op_b = regs[rt];
        endcase
    end

    // control decode, unknown encodings fall through as no-ops
    always_comb begin
        dec              = '0;
        dec.a            = op_a;
        dec.b            = op_b;
        dec.imm          = imm;
        dec.dest         = rt;
        is_beq           = 1'b0;
        is_bne           = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dec.dest         = rd;
                dec.write_enable = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    default: dec.write_enable = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec.use_imm      = 1'b1;
                dec.write_enable = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op       = ALU_LUI;
                dec.use_imm      = 1'b1;
                dec.write_enable = 1'b1;
            end
            OP_LW: begin
                dec.use_imm      = 1'b1;
                dec.mem_read     = 1'b1;
                dec.write_enable = 1'b1;
            end
            OP_SW: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            default: ;
        endcase
        // r0 writes are dropped here
        if (dec.dest == '0) begin
            dec.write_enable = 1'b0;
        end
    end

    // branches resolve here, no delay slot
    assign taken  = (is_beq && op_a == op_b) || (is_bne && op_a != op_b);
    assign target = if_id.pc + 64'd4 + {imm[61:0], 2'b00};

    always_ff @(posedge clock) begin
        if (rst) begin
            pc    <= '0;
            if_id <= '0;
            id_ex <= '0;
        end else if (!mem_wait) begin
            if (stall) begin
                // hold fetch and decode, bubble into ex
                id_ex <= '0;
            end else if (taken) begin
                pc    <= target;
                if_id <= '0;
                id_ex <= dec;
            end else begin
                pc       <= pc + 64'd4;
                if_id.pc   <= pc;
                if_id.inst <= i_data;
                id_ex    <= dec;
            end
        end
    end

    // register file, architectural state starts at zero
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (mem_wb.write_enable) begin
            regs[mem_wb.dest] <= mem_wb.data;
        end
    end

endmodule

/* source/core_execute_mem.sv */
// ##########################################################################
// execute, memory and writeback stages of the core
// alu, ex/mem register, data request, mem/wb register and retire port
// ##########################################################################
`timescale 1ns/1ps

module core_execute_mem
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  id_regs_t  id_ex,
    input  logic      mem_wait,
    input  logic      d_ready,
    input  word_t     d_rdata,
    output ex_regs_t  ex_mem,
    output mem_regs_t mem_wb,
    output addr_t     d_addr,
    output word_t     d_wdata,
    output logic      d_we,
    output logic      d_valid,
    output logic      wb_valid,
    output regnum_t   wb_dest,
    output word_t     wb_data
);

    word_t b_op;
    word_t alu_out;

    // second alu input, immediate for addiu, lui and memory ops
    assign b_op = id_ex.use_imm ? id_ex.imm : id_ex.b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_out = id_ex.a - b_op;
            ALU_AND: alu_out = id_ex.a & b_op;
            ALU_OR:  alu_out = id_ex.a | b_op;
            ALU_SLT: alu_out = {63'd0, $signed(id_ex.a) < $signed(b_op)};
            // upper half of a 32 bit value, sign carried to bit 63
            ALU_LUI: alu_out = {b_op[47:0], 16'h0000};
            default: alu_out = id_ex.a + b_op;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (mem_wait) begin
            // ex_mem holds the request
            // drain wb so a retired write shows only once
            mem_wb <= '0;
        end else begin
            ex_mem.result       <= alu_out;
            ex_mem.store_data   <= id_ex.b;
            ex_mem.mem_read     <= id_ex.mem_read;
            ex_mem.mem_write    <= id_ex.mem_write;
            ex_mem.write_enable <= id_ex.write_enable;
            ex_mem.dest         <= id_ex.dest;
            mem_wb.write_enable <= ex_mem.write_enable;
            mem_wb.dest         <= ex_mem.dest;
            // load data is good in the ready cycle
            mem_wb.data <= (ex_mem.mem_read && d_ready) ? d_rdata : ex_mem.result;
        end
    end

    // data request straight from ex_mem, steady until ready
    assign d_valid = ex_mem.mem_read | ex_mem.mem_write;
    assign d_we    = ex_mem.mem_write;
    assign d_addr  = ex_mem.result;
    assign d_wdata = ex_mem.store_data;

    // retired register write
    assign wb_valid = mem_wb.write_enable;
    assign wb_dest  = mem_wb.dest;
    assign wb_data  = mem_wb.data;

endmodule

/* source/core.sv */
// ##########################################################################
// five-stage pipelined core
// fetches from a combinational rom port, talks valid/ready to data memory
// ##########################################################################
`timescale 1ns/1ps

module core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    // instruction port
    output addr_t   i_addr,
    input  inst_t   i_data,
    // data port
    output addr_t   d_addr,
    output word_t   d_wdata,
    input  word_t   d_rdata,
    output logic    d_we,
    output logic    d_valid,
    input  logic    d_ready,
    // retired register writes
    output logic    wb_valid,
    output regnum_t wb_dest,
    output word_t   wb_data
);

    logic      stall;
    logic      mem_wait;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    regnum_t   rs;
    regnum_t   rt;
    if_regs_t  if_id;
    id_regs_t  id_ex;
    ex_regs_t  ex_mem;
    ex_regs_t  ex_fwd;
    mem_regs_t mem_wb;

    // a load in mem forwards the returned word, not its address
    always_comb begin
        ex_fwd = ex_mem;
        if (ex_mem.mem_read) begin
            ex_fwd.result = d_rdata;
        end
    end

    core_hazard hazard_unit (
        .rs       (rs),
        .rt       (rt),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .stall    (stall),
        .mem_wait (mem_wait),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    core_fetch_decode front_end (
        .clock    (clock),
        .rst      (rst),
        .i_data   (i_data),
        .stall    (stall),
        .mem_wait (mem_wait),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .ex_mem   (ex_fwd),
        .mem_wb   (mem_wb),
        .i_addr   (i_addr),
        .if_id    (if_id),
        .rs       (rs),
        .rt       (rt),
        .id_ex    (id_ex)
    );

    core_execute_mem back_end (
        .clock    (clock),
        .rst      (rst),
        .id_ex    (id_ex),
        .mem_wait (mem_wait),
        .d_ready  (d_ready),
        .d_rdata  (d_rdata),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_we     (d_we),
        .d_valid  (d_valid),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data)
    );

endmodule

/* source/data_ram.sv */
// ##########################################################################
// word-addressed data memory with fixed wait states
// answers a held valid request with a one-cycle ready
// ##########################################################################
`timescale 1ns/1ps

module data_ram
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  we,
    input  logic  valid,
    output logic  ready,
    output word_t rdata
);

    word_t                   mem [RAM_WORDS];
    logic [WAIT_W-1:0]       count;
    logic [RAM_AW-1:0]       idx;

    // 64-bit words, byte offset ignored
    assign idx = addr[RAM_AW+2:3];

    // ready once the wait states are used up
    assign ready = valid && (count == WAIT_W'(RAM_WAIT));
    assign rdata = mem[idx];

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (ready) begin
            count <= '0;
        end else if (valid) begin
            count <= count + 1'b1;
        end
    end

    // store commits in the ready cycle
    always_ff @(posedge clock) begin
        if (ready && we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

/* source/mips_lite_top.sv */
// ##########################################################################
// subsystem top: instruction rom, core and data ram
// the retired register-write stream comes out for observation
// ##########################################################################
`timescale 1ns/1ps

module mips_lite_top
    import isa_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    output logic    wb_valid,
    output regnum_t wb_dest,
    output word_t   wb_data
);

    inst_t rom [ROM_WORDS];
    addr_t i_addr;
    inst_t i_data;
    addr_t d_addr;
    word_t d_wdata;
    word_t d_rdata;
    logic  d_we;
    logic  d_valid;
    logic  d_ready;

    // program image, one instruction per line
    initial begin
        $readmemh("dv/program.hex", rom);
    end

    // combinational fetch, word index from the byte pc
    assign i_data = rom[i_addr[ROM_AW+1:2]];

    core cpu (
        .clock    (clock),
        .rst      (rst),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_rdata  (d_rdata),
        .d_we     (d_we),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data)
    );

    data_ram dmem (
        .clock (clock),
        .rst   (rst),
        .addr  (d_addr),
        .wdata (d_wdata),
        .we    (d_we),
        .valid (d_valid),
        .ready (d_ready),
        .rdata (d_rdata)
    );

endmodule

/* dv/mips_lite_asserts.sv */
// ##########################################################################
// concurrent checks on the core's data handshake and retire port
// attached to every core instance through bind
// ##########################################################################
`timescale 1ns/1ps

module mips_lite_asserts
    import isa_pkg::*;
(
    input logic    clock,
    input logic    rst,
    input logic    d_valid,
    input logic    d_ready,
    input addr_t   d_addr,
    input word_t   d_wdata,
    input logic    d_we,
    input logic    wb_valid,
    input regnum_t wb_dest
);

    // request frozen while the ram is still counting wait states
    req_held: assert property (@(posedge clock) disable iff (rst)
        d_valid && !d_ready |=> d_valid && $stable(d_addr) && $stable(d_we)
            && $stable(d_wdata))
    else $error("data request changed before d_ready");

    // r0 writes never reach the retire port
    no_r0_write: assert property (@(posedge clock) disable iff (rst)
        wb_valid |-> wb_dest != '0)
    else $error("register write retired with r0 as destination");

    // bubbles everywhere once reset has been seen
    idle_after_reset: assert property (@(posedge clock)
        rst |=> !d_valid && !wb_valid)
    else $error("d_valid or wb_valid high right after reset");

endmodule

bind core mips_lite_asserts handshake_checks (
    .clock    (clock),
    .rst      (rst),
    .d_valid  (d_valid),
    .d_ready  (d_ready),
    .d_addr   (d_addr),
    .d_wdata  (d_wdata),
    .d_we     (d_we),
    .wb_valid (wb_valid),
    .wb_dest  (wb_dest)
);

/* dv/tb_mips_lite.sv */
// ##########################################################################
// testbench for the mips_lite subsystem
// runs dv/program.hex on the DUT and checks each retired register write
// against an instruction-level model of the same program
// ##########################################################################
`timescale 1ns/1ps

module tb_mips_lite
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_GROUPS = 5;
    localparam int STEP_LIMIT = 1000;

    logic    clock;
    logic    rst;
    logic    wb_valid;
    regnum_t wb_dest;
    word_t   wb_data;

    // program image and the expected retire stream
    inst_t   prog [ROM_WORDS];
    regnum_t exp_dest [$];
    word_t   exp_data [$];

    // last write index of each group, follows the layout of program.hex
    int    group_last [NUM_GROUPS] = '{9, 15, 18, 22, 26};
    string group_name [NUM_GROUPS] = '{"alu", "forwarding", "load-use",
                                       "memory wait states", "branches"};

    int   errors       = 0;
    int   checked      = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic reset_bad    = 1'b0;
    logic done         = 1'b0;

    mips_lite_top mips_lite_top_inst (
        .clock    (clock),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data)
    );

    // 8 ns clock
    initial clock = 1'b0;
    always #4 clock = ~clock;

    // instruction-level model of the subset, records every non-r0 write
    // returns 1 once the program reaches its branch onto itself
    function automatic bit run_reference();
        word_t   regs [32];
        word_t   mem [RAM_WORDS];
        addr_t   pc;
        addr_t   target;
        addr_t   ea;
        inst_t   inst;
        word_t   a;
        word_t   b;
        word_t   simm;
        word_t   result;
        regnum_t dest;
        logic    wr;
        logic    taken;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < STEP_LIMIT; step++) begin
            inst   = prog[pc[ROM_AW+1:2]];
            a      = regs[inst[25:21]];
            b      = regs[inst[20:16]];
            simm   = {{48{inst[15]}}, inst[15:0]};
            ea     = a + simm;
            // word offset relative to the next instruction
            target = pc + 64'd4 + {simm[61:0], 2'b00};
            dest   = inst[20:16];
            result = '0;
            wr     = 1'b0;
            taken  = 1'b0;
            case (inst[31:26])
                OP_RTYPE: begin
                    dest = inst[15:11];
                    wr   = 1'b1;
                    case (inst[5:0])
                        FN_ADDU: result = a + b;
                        FN_SUBU: result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    result = a + simm;
                    wr     = 1'b1;
                end
                OP_LUI: begin
                    // 32-bit upper immediate, sign carried up to bit 63
                    result = {{32{inst[15]}}, inst[15:0], 16'h0000};
                    wr     = 1'b1;
                end
                OP_LW: begin
                    result = mem[ea[RAM_AW+2:3]];
                    wr     = 1'b1;
                end
                OP_SW:   mem[ea[RAM_AW+2:3]] = b;
                OP_BEQ:  taken = (a == b);
                OP_BNE:  taken = (a != b);
                default: ;
            endcase
            if (wr && dest != '0) begin
                regs[dest] = result;
                exp_dest.push_back(dest);
                exp_data.push_back(result);
            end
            if (taken && target == pc) begin
                return 1'b1;
            end
            pc = taken ? target : pc + 64'd4;
        end
        return 1'b0;
    endfunction

    task automatic check_dest(input int idx, input regnum_t got, input regnum_t exp,
                              output logic ok);
        ok = (got === exp);
        if (!ok) begin
            $display("ERROR at %0d ns: wb_dest is %0d, expected %0d (write %0d)",
                     $time, got, exp, idx);
            errors++;
        end
    endtask

    task automatic check_data(input int idx, input word_t got, input word_t exp,
                              output logic ok);
        ok = (got === exp);
        if (!ok) begin
            $display("ERROR at %0d ns: wb_data is %h, expected %h (write %0d)",
                     $time, got, exp, idx);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input logic bad);
        if (bad) begin
            tests_failed++;
            $display("test %0s: failed at %0d ns", name, $time);
        end else begin
            tests_passed++;
            $display("test %0s: passed at %0d ns", name, $time);
        end
    endtask

    // retire stream checker, sampled mid-cycle where the outputs are settled
    initial begin : compare_writes
        int   idx;
        int   grp;
        logic ok_dest;
        logic ok_data;
        logic grp_bad;
        idx     = 0;
        grp     = 0;
        grp_bad = 1'b0;
        forever begin
            @(negedge clock);
            if (!rst && wb_valid) begin
                if (idx >= exp_dest.size()) begin
                    $display("unexpected register write to r%0d at %0d ns after the last one",
                             wb_dest, $time);
                    errors++;
                end else begin
                    check_dest(idx, wb_dest, exp_dest[idx], ok_dest);
                    check_data(idx, wb_data, exp_data[idx], ok_data);
                    checked++;
                    if (!(ok_dest && ok_data)) begin
                        grp_bad = 1'b1;
                    end
                    // first write after reset closes the reset test
                    if (idx == 0) begin
                        report_test("reset", reset_bad || !(ok_dest && ok_data));
                    end
                    if (grp < NUM_GROUPS && idx == group_last[grp]) begin
                        report_test(group_name[grp], grp_bad);
                        grp++;
                        grp_bad = 1'b0;
                    end
                    idx++;
                    if (idx == exp_dest.size()) begin
                        done = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main
        bit   ref_ok;
        int   limit;
        int   cycles;
        logic timed_out;
        rst       = 1'b1;
        timed_out = 1'b0;
        cycles    = 0;
        $readmemh("dv/program.hex", prog);
        ref_ok = run_reference();
        if (!ref_ok) begin
            $display("reference model never reached the closing self-loop");
            errors++;
        end
        if (exp_dest.size() != group_last[NUM_GROUPS-1] + 1) begin
            $display("reference model gave %0d writes, the test groups need %0d",
                     exp_dest.size(), group_last[NUM_GROUPS-1] + 1);
            errors++;
        end
        // worst case per write is a full pipe plus the ram wait states
        limit = exp_dest.size() * (5 + RAM_WAIT) + 100;
        // 4 reset cycles, retire port quiet throughout
        repeat (4) begin
            @(negedge clock);
            if (wb_valid !== 1'b0) begin
                $display("wb_valid was not low during reset at %0d ns", $time);
                reset_bad = 1'b1;
                errors++;
            end
        end
        rst <= 1'b0;
        while (!done && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            $display("timeout: %0d of %0d register writes seen after %0d cycles",
                     checked, exp_dest.size(), limit);
            timed_out = 1'b1;
        end else begin
            // quiet tail, the self-loop must not retire anything
            repeat (20) @(negedge clock);
        end
        $display("tests passed %0d, failed %0d, writes checked %0d of %0d, errors %0d",
                 tests_passed, tests_failed, checked, exp_dest.size(), errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* mips_lite.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/core_hazard.sv
source/core_fetch_decode.sv
source/core_execute_mem.sv
source/core.sv
source/data_ram.sv
source/mips_lite_top.sv
dv/mips_lite_asserts.sv
dv/tb_mips_lite.sv

/* Makefile */
SIM := obj_dir/Vtb_mips_lite
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): mips_lite.f $(wildcard source/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_lite -f mips_lite.f

# a run fails on the fail message, or when the simulation stopped without a verdict
run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/program.hex */
// instruction words in fetch order, up to four per line, address rising left to right
// the trailing comment names the test group that the line belongs to
24011234 3c028001 2403fffb 240500ff   // alu: addiu r1, lui r2, addiu r3 r5
00222021 00233023 00253824 00254025   // alu: addu subu and or
0061482a 0023502a                     // alu: slt true and false
240c0007 018c6821 240e0003            // forwarding: distance 1
01ac7823 01ee8025 020f8821            // forwarding: distance 1 and 2 chain
24120040 ae440000 8e530000 0261a021   // load-use: base, sw, lw, dependent addu
ae460008 ae420010 8e550010 8e560008   // memory: two stores, two loads back
8e570000 ae550018 8e580018            // memory: reload, store a loaded word
24190001 13200001 241a0002            // branches: beq not taken
17200001 241b0bad                     // branches: bne taken over a flushed addiu
13390001 241b0bad 175a0001            // branches: beq taken, bne not taken
241b600d 037ae021 1000ffff            // branch targets, then self-loop
